/* logic/glue_pkg.sv */
package glue_pkg;

  // bus and sample widths
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] addr_t;
  typedef logic [15:0] sample_t;

  // sound source levels, all unsigned
  typedef logic [11:0] ts_level_t;
  typedef logic [14:0] gs_level_t;
  typedef logic [7:0]  dac_level_t;

  // io port decode
  localparam byte_t      SAA_PORT    = 8'hFF;
  localparam logic [3:0] GS_PORT_HI  = 4'hB;
  localparam logic [2:0] GS_PORT_LO3 = 3'h3;

  // value seen by the cpu when no source drives the bus
  localparam byte_t BUS_IDLE = 8'hFF;

  // clock enable dividers, in fclk cycles
  localparam int RTC_DIV     = 192;
  localparam int YM_DIV      = 8;
  localparam int SAA_DIV     = 7;
  // second saa pulse inside each period
  localparam int SAA_PHASE_B = 3;
  // mixer sample tick period
  localparam int MIX_DIV     = 16;

  // left shifts that place each source in the 16-bit mix
  localparam int TS_SHIFT    = 3;
  localparam int GS_SHIFT    = 1;
  localparam int COVOX_SHIFT = 6;
  localparam int SAA_SHIFT   = 7;
  localparam int BEEP_SHIFT  = 12;

  // port #fe register bits
  localparam int FE_TAPE_BIT = 3;
  localparam int FE_BEEP_BIT = 4;

endpackage

/* logic/cpu_bus_if.sv */
interface cpu_bus_if;

  // z80 address and write data
  glue_pkg::addr_t a;
  glue_pkg::byte_t dw;

  // active low strobes straight from the cpu
  logic iorq_n;
  logic mreq_n;
  logic rd_n;
  logic wr_n;
  logic m1_n;

  // cpu side drives the bus
  modport cpu (
    output a,
    output dw,
    output iorq_n,
    output mreq_n,
    output rd_n,
    output wr_n,
    output m1_n
  );

  // decoders and muxes only look at it
  modport bus (
    input a,
    input dw,
    input iorq_n,
    input mreq_n,
    input rd_n,
    input wr_n,
    input m1_n
  );

endinterface

/* logic/ce_divider.sv */
module ce_divider #(
  parameter int DIVIDE  = 8,
  parameter int PHASE_B = 0
) (
  input  logic fclk,
  input  logic reset,
  output logic ce
);

  localparam int CW = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;

  logic [CW-1:0] cnt;
  logic          last;
  logic          hit_b;

  assign last  = (cnt == CW'(DIVIDE - 1));
  // phase b disabled when zero
  assign hit_b = (PHASE_B != 0) && (cnt == CW'(PHASE_B));

  always_ff @(posedge fclk) begin
    if (reset) begin
      cnt <= '0;
      ce  <= 1'b0;
    end else begin
      if (last) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
      // registered pulse, one cycle behind the count
      ce <= (cnt == '0) || hit_b;
    end
  end

  a_cnt_range: assert property (
    @(posedge fclk) disable iff (reset)
    int'(cnt) < DIVIDE
  ) else $error("ce_divider counter out of range");

endmodule

/* logic/z80_io_decode.sv */
module z80_io_decode (
  input  logic          fclk,
  input  logic          reset,
  cpu_bus_if.bus        bus,
  input  logic          dos,
  output logic          ts_sel,
  output logic          gs_sel,
  output logic          fe_wr,
  output logic          ts_we,
  output logic          gs_cs_n,
  output logic          saa_wr_n,
  output logic          tape_out,
  output logic          beep
);

  logic io_wr;
  logic fe_tape;
  logic fe_beep;

  assign io_wr = ~bus.iorq_n & ~bus.wr_n;

  // turbosound decodes on a15 set, a1 clear and a0 set
  assign ts_sel = ~bus.iorq_n & bus.a[0] & bus.a[15] & ~bus.a[1];
  assign ts_we  = ts_sel & ~bus.wr_n;

  // general sound ports #xB3 and #xBB outside interrupt ack
  assign gs_sel = ~bus.iorq_n & bus.m1_n
                & (bus.a[7:4] == glue_pkg::GS_PORT_HI)
                & (bus.a[2:0] == glue_pkg::GS_PORT_LO3);
  assign gs_cs_n = ~gs_sel;

  // saa1099 hidden while dos rom is paged in
  assign saa_wr_n = ~(io_wr & (bus.a[7:0] == glue_pkg::SAA_PORT) & ~dos);

  // any even port write reaches #fe
  assign fe_wr = io_wr & ~bus.a[0];

  // port #fe keeps only the tape and beeper bits
  always_ff @(posedge fclk) begin
    if (reset) begin
      fe_tape <= 1'b0;
      fe_beep <= 1'b0;
    end else if (fe_wr) begin
      fe_tape <= bus.dw[glue_pkg::FE_TAPE_BIT];
      fe_beep <= bus.dw[glue_pkg::FE_BEEP_BIT];
    end
  end

  assign tape_out = fe_tape;
  assign beep     = fe_beep;

  // the written tape bit must show on the next clock
  a_fe_tape: assert property (
    @(posedge fclk) disable iff (reset)
    fe_wr |=> (tape_out == $past(bus.dw[glue_pkg::FE_TAPE_BIT]))
  ) else $error("tape_out did not follow port #fe write");

endmodule

/* logic/z80_read_mux.sv */
module z80_read_mux (
  cpu_bus_if.bus          bus,
  input  logic            gs_sel,
  input  logic            ts_sel,
  input  logic            zifi_dataout,
  input  logic            ports_ena,
  input  logic            intack,
  input  glue_pkg::byte_t ram_dout,
  input  glue_pkg::byte_t gs_dout,
  input  glue_pkg::byte_t ts_dout,
  input  glue_pkg::byte_t zifi_dout,
  input  glue_pkg::byte_t ports_dout,
  input  glue_pkg::byte_t im2vect,
  output glue_pkg::byte_t di
);

  logic rd;

  assign rd = ~bus.rd_n;

  // fixed priority, memory first
  always_comb begin
    if (~bus.mreq_n && rd) begin
      di = ram_dout;
    end else if (gs_sel && rd) begin
      di = gs_dout;
    end else if (ts_sel && rd) begin
      di = ts_dout;
    end else if (zifi_dataout && rd) begin
      di = zifi_dout;
    end else if (ports_ena) begin
      // port block qualifies its own read
      di = ports_dout;
    end else if (intack) begin
      di = im2vect;
    end else begin
      di = glue_pkg::BUS_IDLE;
    end
  end

endmodule

/* logic/audio_mixer.sv */
module audio_mixer #(
  parameter int MIX_DIV = 16
) (
  input  logic                 fclk,
  input  logic                 reset,
  input  glue_pkg::ts_level_t  ts_l,
  input  glue_pkg::ts_level_t  ts_r,
  input  glue_pkg::gs_level_t  gs_l,
  input  glue_pkg::gs_level_t  gs_r,
  input  glue_pkg::dac_level_t covox_a,
  input  glue_pkg::dac_level_t covox_b,
  input  glue_pkg::dac_level_t covox_c,
  input  glue_pkg::dac_level_t covox_d,
  input  glue_pkg::dac_level_t saa_l,
  input  glue_pkg::dac_level_t saa_r,
  input  logic                 beep,
  output glue_pkg::sample_t    sample_l,
  output glue_pkg::sample_t    sample_r,
  output logic                 sample_valid,
  input  logic                 sample_ready
);

  // ts, gs, two covox, saa, beeper
  localparam int NTERM = 6;

  logic              tick;
  logic              s1_valid;
  logic              out_free;
  logic              s2_load;
  logic              capture;
  glue_pkg::sample_t term_l [NTERM];
  glue_pkg::sample_t term_r [NTERM];
  glue_pkg::sample_t sum_l;
  glue_pkg::sample_t sum_r;

  ce_divider #(
    .DIVIDE  (MIX_DIV),
    .PHASE_B (0)
  ) u_tick (
    .fclk  (fclk),
    .reset (reset),
    .ce    (tick)
  );

  // output register empty or being taken this cycle
  assign out_free = ~sample_valid | sample_ready;
  assign s2_load  = s1_valid & out_free;
  // a tick that finds stage 1 stuck is lost
  assign capture  = tick & (~s1_valid | out_free);

  // stage 1, capture and scale
  always_ff @(posedge fclk) begin
    if (capture) begin
      term_l[0] <= glue_pkg::sample_t'(ts_l) << glue_pkg::TS_SHIFT;
      term_l[1] <= glue_pkg::sample_t'(gs_l) << glue_pkg::GS_SHIFT;
      term_l[2] <= glue_pkg::sample_t'(covox_a) << glue_pkg::COVOX_SHIFT;
      term_l[3] <= glue_pkg::sample_t'(covox_b) << glue_pkg::COVOX_SHIFT;
      term_l[4] <= glue_pkg::sample_t'(saa_l) << glue_pkg::SAA_SHIFT;
      term_l[5] <= glue_pkg::sample_t'(beep) << glue_pkg::BEEP_SHIFT;
      term_r[0] <= glue_pkg::sample_t'(ts_r) << glue_pkg::TS_SHIFT;
      term_r[1] <= glue_pkg::sample_t'(gs_r) << glue_pkg::GS_SHIFT;
      term_r[2] <= glue_pkg::sample_t'(covox_c) << glue_pkg::COVOX_SHIFT;
      term_r[3] <= glue_pkg::sample_t'(covox_d) << glue_pkg::COVOX_SHIFT;
      term_r[4] <= glue_pkg::sample_t'(saa_r) << glue_pkg::SAA_SHIFT;
      term_r[5] <= glue_pkg::sample_t'(beep) << glue_pkg::BEEP_SHIFT;
    end
  end

  // wraps modulo 2^16
  always_comb begin
    sum_l = '0;
    sum_r = '0;
    for (int i = 0; i < NTERM; i++) begin
      sum_l = sum_l + term_l[i];
      sum_r = sum_r + term_r[i];
    end
  end

  // stage 2, sums held until taken
  always_ff @(posedge fclk) begin
    if (s2_load) begin
      sample_l <= sum_l;
      sample_r <= sum_r;
    end
  end

  always_ff @(posedge fclk) begin
    if (reset) begin
      s1_valid     <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      if (capture) begin
        s1_valid <= 1'b1;
      end else if (s2_load) begin
        s1_valid <= 1'b0;
      end
      if (out_free) begin
        sample_valid <= s1_valid;
      end
    end
  end

  a_hold_stable: assert property (
    @(posedge fclk) disable iff (reset)
    (sample_valid && !sample_ready)
      |=> (sample_valid && $stable(sample_l) && $stable(sample_r))
  ) else $error("mixer sample changed while stalled");

endmodule

/* logic/spectrum_io_glue.sv */
module spectrum_io_glue #(
  parameter int MIX_DIV = glue_pkg::MIX_DIV
) (
  input  logic                 fclk,
  input  logic                 reset,
  input  glue_pkg::addr_t      a,
  input  glue_pkg::byte_t      dw,
  input  logic                 iorq_n,
  input  logic                 mreq_n,
  input  logic                 rd_n,
  input  logic                 wr_n,
  input  logic                 m1_n,
  input  logic                 dos,
  input  logic                 intack,
  input  glue_pkg::byte_t      ram_dout,
  input  glue_pkg::byte_t      gs_dout,
  input  glue_pkg::byte_t      ts_dout,
  input  glue_pkg::byte_t      zifi_dout,
  input  glue_pkg::byte_t      ports_dout,
  input  glue_pkg::byte_t      im2vect,
  input  logic                 zifi_dataout,
  input  logic                 ports_ena,
  input  glue_pkg::ts_level_t  ts_l,
  input  glue_pkg::ts_level_t  ts_r,
  input  glue_pkg::gs_level_t  gs_l,
  input  glue_pkg::gs_level_t  gs_r,
  input  glue_pkg::dac_level_t covox_a,
  input  glue_pkg::dac_level_t covox_b,
  input  glue_pkg::dac_level_t covox_c,
  input  glue_pkg::dac_level_t covox_d,
  input  glue_pkg::dac_level_t saa_l,
  input  glue_pkg::dac_level_t saa_r,
  input  logic                 sample_ready,
  output glue_pkg::byte_t      di,
  output logic                 ts_we,
  output logic                 gs_cs_n,
  output logic                 saa_wr_n,
  output logic                 tape_out,
  output logic                 ce_rtc,
  output logic                 ce_ym,
  output logic                 ce_saa,
  output glue_pkg::sample_t    sample_l,
  output glue_pkg::sample_t    sample_r,
  output logic                 sample_valid
);

  logic ts_sel;
  logic gs_sel;
  logic beep;

  cpu_bus_if bus ();

  // cpu pins onto the shared bus
  assign bus.a      = a;
  assign bus.dw     = dw;
  assign bus.iorq_n = iorq_n;
  assign bus.mreq_n = mreq_n;
  assign bus.rd_n   = rd_n;
  assign bus.wr_n   = wr_n;
  assign bus.m1_n   = m1_n;

  z80_io_decode u_decode (
    .fclk     (fclk),
    .reset    (reset),
    .bus      (bus.bus),
    .dos      (dos),
    .ts_sel   (ts_sel),
    .gs_sel   (gs_sel),
    .fe_wr    (),
    .ts_we    (ts_we),
    .gs_cs_n  (gs_cs_n),
    .saa_wr_n (saa_wr_n),
    .tape_out (tape_out),
    .beep     (beep)
  );

  z80_read_mux u_read_mux (
    .bus          (bus.bus),
    .gs_sel       (gs_sel),
    .ts_sel       (ts_sel),
    .zifi_dataout (zifi_dataout),
    .ports_ena    (ports_ena),
    .intack       (intack),
    .ram_dout     (ram_dout),
    .gs_dout      (gs_dout),
    .ts_dout      (ts_dout),
    .zifi_dout    (zifi_dout),
    .ports_dout   (ports_dout),
    .im2vect      (im2vect),
    .di           (di)
  );

  audio_mixer #(
    .MIX_DIV (MIX_DIV)
  ) u_mixer (
    .fclk         (fclk),
    .reset        (reset),
    .ts_l         (ts_l),
    .ts_r         (ts_r),
    .gs_l         (gs_l),
    .gs_r         (gs_r),
    .covox_a      (covox_a),
    .covox_b      (covox_b),
    .covox_c      (covox_c),
    .covox_d      (covox_d),
    .saa_l        (saa_l),
    .saa_r        (saa_r),
    .beep         (beep),
    .sample_l     (sample_l),
    .sample_r     (sample_r),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready)
  );

  // rtc core enable
  ce_divider #(
    .DIVIDE  (glue_pkg::RTC_DIV),
    .PHASE_B (0)
  ) u_ce_rtc (
    .fclk  (fclk),
    .reset (reset),
    .ce    (ce_rtc)
  );

  ce_divider #(
    .DIVIDE  (glue_pkg::YM_DIV),
    .PHASE_B (0)
  ) u_ce_ym (
    .fclk  (fclk),
    .reset (reset),
    .ce    (ce_ym)
  );

  // saa gets two pulses every seven clocks
  ce_divider #(
    .DIVIDE  (glue_pkg::SAA_DIV),
    .PHASE_B (glue_pkg::SAA_PHASE_B)
  ) u_ce_saa (
    .fclk  (fclk),
    .reset (reset),
    .ce    (ce_saa)
  );

endmodule

/* bench/tb_ref.svh */
`ifndef TB_REF_SVH
`define TB_REF_SVH

// 32-bit lcg, full period modulo 2^32
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// turbosound: a15 high, a1 low, a0 high
function automatic logic ref_ts_sel(input logic [15:0] a, input logic iorq_n);
  return !iorq_n && a[0] && a[15] && !a[1];
endfunction

// general sound: high nibble B, low bits 3, no interrupt ack
function automatic logic ref_gs_sel(input logic [15:0] a, input logic iorq_n, input logic m1_n);
  return !iorq_n && m1_n && (a[7:4] == 4'hB) && (a[2:0] == 3'h3);
endfunction

// packed as {ts_we, gs_cs_n, saa_wr_n}
function automatic logic [2:0] ref_decode(
  input logic [15:0] a,
  input logic        iorq_n, wr_n, m1_n, dos
);
  logic ts_we;
  logic gs_cs_n;
  logic saa_wr_n;
  ts_we    = ref_ts_sel(a, iorq_n) && !wr_n;
  gs_cs_n  = !ref_gs_sel(a, iorq_n, m1_n);
  saa_wr_n = !(!iorq_n && !wr_n && (a[7:0] == 8'hFF) && !dos);
  return {ts_we, gs_cs_n, saa_wr_n};
endfunction

// first match wins, idle bus reads all ones
function automatic logic [7:0] ref_read(
  input logic [15:0] a,
  input logic        iorq_n, mreq_n, rd_n, m1_n,
  input logic        zifi_dataout, ports_ena, intack,
  input logic [7:0]  ram, gs, ts, zifi, ports, vect
);
  logic rd;
  rd = !rd_n;
  if (!mreq_n && rd) return ram;
  if (ref_gs_sel(a, iorq_n, m1_n) && rd) return gs;
  if (ref_ts_sel(a, iorq_n) && rd) return ts;
  if (zifi_dataout && rd) return zifi;
  if (ports_ena) return ports;
  if (intack) return vect;
  return 8'hFF;
endfunction

// one channel, wraps at 16 bits
function automatic logic [15:0] ref_mix(
  input logic [11:0] ts,
  input logic [14:0] gs,
  input logic [7:0]  dac_a, dac_b, saa,
  input logic        beep
);
  logic [31:0] acc;
  acc = ({20'd0, ts} << 3) + ({17'd0, gs} << 1)
      + ({24'd0, dac_a} << 6) + ({24'd0, dac_b} << 6)
      + ({24'd0, saa} << 7) + ({31'd0, beep} << 12);
  return acc[15:0];
endfunction

`endif

/* bench/tb_spectrum_io_glue.sv */
module tb_spectrum_io_glue;

  localparam int PERIOD      = 8;
  localparam int RESET_CYC   = 4;
  localparam int BUS_CYC     = 600;
  localparam int SEG_CNT     = 12;
  localparam int SEG_CYC     = 160;
  localparam int TOTAL_CYC   = RESET_CYC + BUS_CYC + SEG_CNT * SEG_CYC + 8;
  localparam int MARGIN      = 2000;
  localparam int MIN_SAMPLES = 40;

  `include "tb_ref.svh"

  logic fclk;
  logic reset;
  glue_pkg::addr_t a;
  glue_pkg::byte_t dw;
  logic iorq_n, mreq_n, rd_n, wr_n, m1_n, dos, intack;
  glue_pkg::byte_t ram_dout, gs_dout, ts_dout, zifi_dout, ports_dout, im2vect;
  logic zifi_dataout, ports_ena;
  glue_pkg::ts_level_t ts_l, ts_r;
  glue_pkg::gs_level_t gs_l, gs_r;
  glue_pkg::dac_level_t covox_a, covox_b, covox_c, covox_d, saa_l, saa_r;
  logic sample_ready;
  glue_pkg::byte_t di;
  logic ts_we, gs_cs_n, saa_wr_n, tape_out;
  logic ce_rtc, ce_ym, ce_saa;
  glue_pkg::sample_t sample_l, sample_r;
  logic sample_valid;

  logic [31:0] rng_state;
  int err_value;
  int err_other;
  int checked;
  int cycle;
  int skip;
  logic exp_tape, exp_beep;
  logic [15:0] exp_l, exp_r, held_l, held_r;
  logic prev_hold;
  int last_ym, last_rtc, last_saa;
  int gap_ym, gap_rtc, gap_saa;
  int n_ym, n_rtc, n_saa;

  spectrum_io_glue u_spectrum_io_glue (.*);

  always #(PERIOD / 2) fclk = ~fclk;

  // two lcg steps, upper halves only
  task automatic draw(output logic [31:0] r);
    logic [15:0] hi;
    rng_state = lcg_next(rng_state);
    hi = rng_state[31:16];
    rng_state = lcg_next(rng_state);
    r = {hi, rng_state[31:16]};
  endtask

  // io cycles suppressed when io_on is low
  task automatic drive_bus_random(input logic io_on);
    logic [31:0] r0, r1, r2;
    draw(r0);
    draw(r1);
    draw(r2);
    // bias toward the exact saa and gs ports
    case (r0[1:0])
      2'd0: a = {r0[15:8], 8'hFF};
      2'd1: a = {r0[15:8], 4'hB, r0[2], 3'h3};
      default: a = r0[31:16];
    endcase
    dw           = r1[7:0];
    iorq_n       = io_on ? r1[8] : 1'b1;
    mreq_n       = r1[9];
    rd_n         = r1[10];
    wr_n         = r1[11];
    m1_n         = r1[12];
    dos          = r1[13];
    intack       = r1[14];
    zifi_dataout = r1[15];
    ports_ena    = r1[16] & r1[17];
    im2vect      = r1[23:16];
    ram_dout     = r1[31:24];
    gs_dout      = r2[7:0];
    ts_dout      = r2[15:8];
    zifi_dout    = r2[23:16];
    ports_dout   = r2[31:24];
  endtask

  task automatic drive_levels_random();
    logic [31:0] r0, r1, r2, r3;
    draw(r0);
    draw(r1);
    draw(r2);
    draw(r3);
    ts_l    = r0[11:0];
    ts_r    = r0[23:12];
    gs_l    = r1[14:0];
    gs_r    = r1[29:15];
    covox_a = r2[7:0];
    covox_b = r2[15:8];
    covox_c = r2[23:16];
    covox_d = r2[31:24];
    saa_l   = r3[7:0];
    saa_r   = r3[15:8];
  endtask

  task automatic check_bus();
    logic [7:0] exp_di;
    logic [2:0] exp_dec;
    exp_di = ref_read(a, iorq_n, mreq_n, rd_n, m1_n, zifi_dataout, ports_ena, intack,
                      ram_dout, gs_dout, ts_dout, zifi_dout, ports_dout, im2vect);
    exp_dec = ref_decode(a, iorq_n, wr_n, m1_n, dos);
    assert (di === exp_di) else begin
      err_value++;
      $display("[ERROR] %0t: di is %h, expected %h (a=%h)", $time, di, exp_di, a);
    end
    assert ({ts_we, gs_cs_n, saa_wr_n} === exp_dec) else begin
      err_value++;
      $display("[ERROR] %0t: ts_we/gs_cs_n/saa_wr_n are %b, expected %b (a=%h)",
               $time, {ts_we, gs_cs_n, saa_wr_n}, exp_dec, a);
    end
    assert (tape_out === exp_tape) else begin
      err_value++;
      $display("[ERROR] %0t: tape_out is %b, expected %b", $time, tape_out, exp_tape);
    end
  endtask

  task automatic check_samples();
    logic [15:0] cur_l, cur_r;
    cur_l = ref_mix(ts_l, gs_l, covox_a, covox_b, saa_l, exp_beep);
    cur_r = ref_mix(ts_r, gs_r, covox_c, covox_d, saa_r, exp_beep);
    if (prev_hold) begin
      assert (sample_valid && sample_l === held_l && sample_r === held_r) else begin
        err_other++;
        $display("mixer output changed while the sink was stalling, time %0t", $time);
      end
    end
    if (sample_valid && sample_ready) begin
      if (skip > 0) begin
        skip--;
      end else begin
        checked++;
        assert (sample_l === exp_l && sample_r === exp_r) else begin
          err_value++;
          $display("[ERROR] %0t: sample is %h/%h, expected %h/%h",
                   $time, sample_l, sample_r, exp_l, exp_r);
        end
      end
    end
    // samples already in flight carry the old levels
    if (cur_l !== exp_l || cur_r !== exp_r) begin
      exp_l = cur_l;
      exp_r = cur_r;
      skip  = 2;
    end
    prev_hold = sample_valid && !sample_ready;
    held_l    = sample_l;
    held_r    = sample_r;
  endtask

  task automatic check_pulse(input logic ce, input int gap_a, input int gap_b,
                             input string name, inout int last, inout int last_gap,
                             inout int pulses);
    int gap;
    int max_gap;
    max_gap = (gap_a > gap_b) ? gap_a : gap_b;
    if (ce) begin
      pulses++;
      if (last < 0) begin
        assert (cycle == 1) else begin
          err_other++;
          $display("first %s pulse came at cycle %0d after reset, not cycle 1", name, cycle);
        end
      end else begin
        gap = cycle - last;
        assert ((gap == gap_a || gap == gap_b) && (gap_a == gap_b || gap != last_gap))
        else begin
          err_other++;
          $display("%s pulse came %0d cycles after the previous one, time %0t",
                   name, gap, $time);
        end
        last_gap = gap;
      end
      last = cycle;
    end else if (last >= 0) begin
      assert (cycle - last < max_gap) else begin
        err_other++;
        $display("%s pulse missing at time %0t", name, $time);
      end
    end
  endtask

  // compare at the falling edge, inputs and outputs are settled
  always @(negedge fclk) begin
    if (reset) begin
      assert (!ce_rtc && !ce_ym && !ce_saa) else begin
        err_other++;
        $display("a clock enable was high during reset, time %0t", $time);
      end
      exp_tape  = 1'b0;
      exp_beep  = 1'b0;
      skip      = 2;
      prev_hold = 1'b0;
      cycle     = 0;
    end else begin
      check_bus();
      check_samples();
      check_pulse(ce_ym, 8, 8, "ce_ym", last_ym, gap_ym, n_ym);
      check_pulse(ce_rtc, 192, 192, "ce_rtc", last_rtc, gap_rtc, n_rtc);
      check_pulse(ce_saa, 3, 4, "ce_saa", last_saa, gap_saa, n_saa);
      // port #fe loads on the coming edge
      if (!iorq_n && !wr_n && !a[0]) begin
        exp_tape = dw[3];
        exp_beep = dw[4];
      end
      cycle++;
    end
  end

  initial begin
    #(TOTAL_CYC * PERIOD + MARGIN);
    $display("timeout: stimulus did not complete in the expected time");
    $display("Checks failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    rng_state = 32'd12508;
    err_value = 0;
    err_other = 0;
    checked   = 0;
    last_ym   = -1;
    last_rtc  = -1;
    last_saa  = -1;
    gap_ym    = 0;
    gap_rtc   = 0;
    gap_saa   = 0;
    n_ym      = 0;
    n_rtc     = 0;
    n_saa     = 0;
    exp_l     = '0;
    exp_r     = '0;
    fclk      = 1'b0;
    reset     = 1'b1;
    sample_ready = 1'b1;
    drive_bus_random(1'b0);
    drive_levels_random();
    repeat (RESET_CYC) @(posedge fclk);
    #1 reset = 1'b0;

    // random bus traffic, levels fixed
    for (int i = 0; i < BUS_CYC; i++) begin
      @(posedge fclk);
      #1;
      drive_bus_random(1'b1);
    end

    // mixer segments, new levels and beeper write at each start
    for (int seg = 0; seg < SEG_CNT; seg++) begin
      for (int i = 0; i < SEG_CYC; i++) begin
        @(posedge fclk);
        #1;
        drive_bus_random(1'b0);
        draw(r);
        if (i == 0) begin
          drive_levels_random();
          iorq_n = 1'b0;
          wr_n   = 1'b0;
          rd_n   = 1'b1;
          a[0]   = 1'b0;
        end
        case (seg % 3)
          0: sample_ready = 1'b1;
          1: sample_ready = r[20];
          default: sample_ready = r[20] & r[21];
        endcase
      end
    end

    @(posedge fclk);
    #1 sample_ready = 1'b1;
    repeat (4) @(posedge fclk);
    @(negedge fclk);
    #1;
    assert (checked >= MIN_SAMPLES) else begin
      err_other++;
      $display("only %0d mixer samples were compared", checked);
    end
    assert (n_rtc > 0 && n_ym > 0 && n_saa > 0) else begin
      err_other++;
      $display("a clock enable never pulsed");
    end
    $display("summary: %0d value errors, %0d other errors, %0d samples compared",
             err_value, err_other, checked);
    if (err_value == 0 && err_other == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+bench
logic/glue_pkg.sv
logic/cpu_bus_if.sv
logic/ce_divider.sv
logic/z80_io_decode.sv
logic/z80_read_mux.sv
logic/audio_mixer.sv
logic/spectrum_io_glue.sv
bench/tb_spectrum_io_glue.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f src.f \
  --top-module tb_spectrum_io_glue \
  --Mdir obj_dir -o tb_sim

status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation result: FAIL"
  exit 1
fi
echo "simulation result: PASS"
